// File: logic/bit_scan_macros.svh
`ifndef BIT_SCAN_MACROS_SVH
`define BIT_SCAN_MACROS_SVH

// ------------------------------
// operand and scan geometry
// ------------------------------

`define BSU_OPERAND_WIDTH 64    // full operand.
`define BSU_CHUNK_WIDTH   32    // bits looked at per clock.
`define BSU_CHUNK_COUNT   2     // operand / chunk.

// ------------------------------
// result widths
// ------------------------------

`define BSU_INDEX_WIDTH   6     // index into the operand.
`define BSU_ENC_WIDTH     5     // index inside one chunk.

`endif

// File: logic/bit_scan_pkg.sv
`default_nettype none

`include "bit_scan_macros.svh"

package bit_scan_pkg;

    // ------------------------------
    // scan direction
    // ------------------------------

    // fwd is bsf, rev is bsr.
    typedef enum logic {
        SCAN_FWD = 1'b0,    // lowest set bit.
        SCAN_REV = 1'b1     // highest set bit.
    } scan_dir_e;

    // ------------------------------
    // control states
    // ------------------------------

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,     // waiting for req.
        ST_SCAN = 2'd1,     // one chunk per clock.
        ST_DONE = 2'd2      // ack high, waiting for req low.
    } scan_state_e;

    // ------------------------------
    // handshake payloads
    // ------------------------------

    typedef struct packed {
        logic [`BSU_OPERAND_WIDTH-1:0] operand;
        scan_dir_e                     dir;
    } scan_req_t;

    // index is 0 whenever zero is set.
    typedef struct packed {
        logic [`BSU_INDEX_WIDTH-1:0] index;
        logic                        zero;
    } scan_rsp_t;

endpackage

`default_nettype wire

// File: logic/priority_encoder32.sv
`timescale 1ns/1ps
`default_nettype none

`include "bit_scan_macros.svh"

module priority_encoder32 (
    input  logic [`BSU_CHUNK_WIDTH-1:0] chunk,
    output logic [`BSU_ENC_WIDTH-1:0]   enc,
    output logic                        valid
);

    localparam int SLICE_W = 8;
    localparam int SLICES  = `BSU_CHUNK_WIDTH / SLICE_W;

    logic [2:0]        slice_pos [SLICES];  // in-slice position.
    logic [SLICES-1:0] slice_valid;
    logic [1:0]        slice_sel;

    // ------------------------------
    // first level, one per byte
    // ------------------------------

    for (genvar s = 0; s < SLICES; s++) begin : g_slice
        // scan from the top so the lowest hit wins.
        always_comb begin
            slice_pos[s] = 3'd0;
            for (int b = SLICE_W - 1; b >= 0; b--) begin
                if (chunk[s*SLICE_W + b]) begin
                    slice_pos[s] = 3'(b);
                end
            end
        end

        assign slice_valid[s] = |chunk[s*SLICE_W +: SLICE_W];
    end

    // ------------------------------
    // second level, pick the slice
    // ------------------------------

    always_comb begin
        slice_sel = 2'd0;
        for (int s = SLICES - 1; s >= 0; s--) begin
            if (slice_valid[s]) begin
                slice_sel = 2'(s);    // lowest valid slice.
            end
        end
    end

    assign valid = |slice_valid;
    assign enc   = {slice_sel, slice_pos[slice_sel]};    // slice number, then offset.

    // the encoded bit must really be set.
    always_comb begin
        assert final (!valid || chunk[enc])
            else $error("encoder points at a clear bit.");
    end

endmodule

`default_nettype wire

// File: logic/scan_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "bit_scan_macros.svh"

module scan_datapath (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load,
    input  logic                    done_set,
    input  bit_scan_pkg::scan_req_t req_data,
    input  logic                    pos,
    output logic                    hit,
    output bit_scan_pkg::scan_rsp_t rsp_data
);

    import bit_scan_pkg::*;

    logic [`BSU_OPERAND_WIDTH-1:0] operand_q;
    scan_dir_e                     dir_q;
    logic                          chunk_sel;
    logic [`BSU_CHUNK_WIDTH-1:0]   raw_chunk;
    logic [`BSU_CHUNK_WIDTH-1:0]   scan_chunk;
    logic [`BSU_ENC_WIDTH-1:0]     enc;
    logic [`BSU_INDEX_WIDTH-1:0]   lin_index;
    logic [`BSU_INDEX_WIDTH-1:0]   bit_index;
    scan_rsp_t                     rsp_q;

    // ------------------------------
    // operand capture
    // ------------------------------

    always_ff @(posedge clk) begin
        if (load) begin
            operand_q <= req_data.operand;
            dir_q     <= req_data.dir;
        end
    end

    // ------------------------------
    // chunk select and reversal
    // ------------------------------

    // reverse scan walks the chunks from the top down.
    assign chunk_sel = (dir_q == SCAN_REV) ? ~pos : pos;
    assign raw_chunk = operand_q[chunk_sel*`BSU_CHUNK_WIDTH +: `BSU_CHUNK_WIDTH];

    // mirrored so the encoder always hunts the lowest bit.
    always_comb begin
        for (int i = 0; i < `BSU_CHUNK_WIDTH; i++) begin
            if (dir_q == SCAN_REV) begin
                scan_chunk[i] = raw_chunk[`BSU_CHUNK_WIDTH-1-i];
            end else begin
                scan_chunk[i] = raw_chunk[i];
            end
        end
    end

    priority_encoder32 i_enc (
        .chunk (scan_chunk),
        .enc   (enc),
        .valid (hit)
    );

    // ------------------------------
    // index assembly and result
    // ------------------------------

    assign lin_index = {pos, enc};    // pos * 32 + enc.
    assign bit_index = (dir_q == SCAN_REV) ?
                       `BSU_INDEX_WIDTH'(`BSU_OPERAND_WIDTH - 1) - lin_index : lin_index;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_q <= '0;
        end else if (done_set) begin
            rsp_q.zero  <= ~hit;                           // last chunk, nothing found.
            rsp_q.index <= hit ? bit_index : '0;
        end
    end

    assign rsp_data = rsp_q;

    // capture and result never share an edge.
    a_no_load_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(load && done_set));

endmodule

`default_nettype wire

// File: logic/chunk_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "bit_scan_macros.svh"

module chunk_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    input  logic advance,
    output logic pos,
    output logic last
);

    logic pos_q;

    // clear wins over advance.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos_q <= 1'b0;
        end else if (clear) begin
            pos_q <= 1'b0;
        end else if (advance) begin
            pos_q <= pos_q + 1'b1;
        end
    end

    assign pos  = pos_q;
    assign last = (pos_q == 1'(`BSU_CHUNK_COUNT - 1));    // final chunk.

    // the fsm must stop stepping at the last chunk.
    a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        advance |-> !last);

endmodule

`default_nettype wire

// File: logic/bit_scan_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module bit_scan_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic req,
    input  logic hit,
    input  logic last,
    output logic ack,
    output logic load,
    output logic clear,
    output logic advance,
    output logic done_set
);

    import bit_scan_pkg::*;

    scan_state_e state_q;
    scan_state_e state_d;
    logic        ack_q;

    // ------------------------------
    // next state and strobes
    // ------------------------------

    always_comb begin
        state_d  = state_q;
        load     = 1'b0;
        clear    = 1'b0;
        advance  = 1'b0;
        done_set = 1'b0;

        case (state_q)
            ST_IDLE: begin
                if (req) begin
                    load    = 1'b1;    // grab operand.
                    clear   = 1'b1;    // restart at chunk 0.
                    state_d = ST_SCAN;
                end
            end

            ST_SCAN: begin
                // stop on the first hit or after the last chunk.
                if (hit || last) begin
                    done_set = 1'b1;
                    state_d  = ST_DONE;
                end else begin
                    advance = 1'b1;
                end
            end

            ST_DONE: begin
                if (!req) begin
                    state_d = ST_IDLE;    // phase 4.
                end
            end

            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // ------------------------------
    // state and ack registers
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // rises with the result, drops once req is seen low.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else if (done_set) begin
            ack_q <= 1'b1;
        end else if (state_q == ST_DONE && !req) begin
            ack_q <= 1'b0;
        end
    end

    assign ack = ack_q;

    a_ack_in_done: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> state_q == ST_DONE);

endmodule

`default_nettype wire

// File: logic/bit_scan_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bit_scan_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,
    input  bit_scan_pkg::scan_req_t req_data,
    output logic                    ack,
    output bit_scan_pkg::scan_rsp_t rsp_data
);

    // ------------------------------
    // internal wires
    // ------------------------------

    logic load;
    logic clear;
    logic advance;
    logic done_set;
    logic pos;        // chunk under scan.
    logic last;
    logic hit;        // current chunk has a set bit.

    bit_scan_fsm i_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .hit      (hit),
        .last     (last),
        .ack      (ack),
        .load     (load),
        .clear    (clear),
        .advance  (advance),
        .done_set (done_set)
    );

    chunk_counter i_cnt (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (clear),
        .advance (advance),
        .pos     (pos),
        .last    (last)
    );

    scan_datapath i_dp (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .done_set (done_set),
        .req_data (req_data),
        .pos      (pos),
        .hit      (hit),
        .rsp_data (rsp_data)
    );

endmodule

`default_nettype wire

// File: bench/bit_scan_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bit_scan_macros.svh"

module bit_scan_tb;

    import bit_scan_pkg::*;

    localparam int RST_CYCLES  = 5;
    localparam int SINGLE_REQ  = 2 * `BSU_OPERAND_WIDTH;    // every bit, both ways.
    localparam int ZERO_REQ    = 2;
    localparam int CHUNK_REQ   = 16;
    localparam int RAND_REQ    = 300;
    localparam int NUM_REQ     = SINGLE_REQ + ZERO_REQ + CHUNK_REQ + RAND_REQ;
    localparam int CYCLE_LIMIT = NUM_REQ * 10 + RST_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        req;
    logic        ack;
    scan_req_t   req_data;
    scan_rsp_t   rsp_data;

    scan_rsp_t   exp_rsp;           // expected result of the request in flight.
    string       exp_name;
    int          n_sent      = 0;
    int          n_checked   = 0;
    int          cycle_count = 0;

    bit_scan_unit i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // reference model and checks
    // ------------------------------

    function automatic scan_rsp_t ref_scan(input logic [63:0] operand, input scan_dir_e dir);
        scan_rsp_t rsp;
        logic      found;
        rsp      = '0;
        rsp.zero = 1'b1;
        found    = 1'b0;
        if (dir == SCAN_FWD) begin
            for (int i = 0; i < `BSU_OPERAND_WIDTH; i++) begin
                if (!found && operand[i]) begin
                    found     = 1'b1;
                    rsp.index = 6'(i);
                end
            end
        end else begin
            for (int i = `BSU_OPERAND_WIDTH - 1; i >= 0; i--) begin
                if (!found && operand[i]) begin
                    found     = 1'b1;
                    rsp.index = 6'(i);
                end
            end
        end
        rsp.zero = ~found;
        return rsp;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopped at the first mismatch.");
        end
    endtask

    // sparse words come from anding several random words.
    function automatic logic [63:0] random_operand();
        int unsigned kind;
        logic [63:0] word;
        kind = $urandom_range(0, 3);
        word = {$urandom(), $urandom()};
        repeat (kind * 2) begin
            word = word & {$urandom(), $urandom()};
        end
        return word;
    endfunction

    // compare mid-cycle after each rising ack.
    always @(posedge ack) begin
        @(negedge clk);
        check(exp_name, 64'(exp_rsp), 64'(rsp_data));
        n_checked++;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped at the cycle limit.");
        end
    end

    // ------------------------------
    // one four-phase transfer
    // ------------------------------

    task automatic run_scan(input logic [63:0] operand, input scan_dir_e dir,
                            input string name);
        int unsigned hold;
        scan_rsp_t   held;
        hold     = $urandom_range(0, 2);    // extra cycles with req kept high.
        exp_rsp  = ref_scan(operand, dir);
        exp_name = name;
        @(posedge clk);
        req              <= 1'b1;
        req_data.operand <= operand;
        req_data.dir     <= dir;
        n_sent++;
        while (!ack) @(posedge clk);
        held = rsp_data;
        repeat (hold) begin
            @(posedge clk);
            check({name, " ack hold"}, 64'd1, 64'(ack));
            check({name, " rsp hold"}, 64'(held), 64'(rsp_data));
        end
        req <= 1'b0;
        @(posedge clk);                      // unit sees req low here.
        check({name, " ack before req low"}, 64'd1, 64'(ack));
        @(posedge clk);
        check({name, " ack fall"}, 64'd0, 64'(ack));
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------

    initial begin
        logic [63:0] operand;
        scan_dir_e   dir;
        void'($urandom(32'ha1cb));
        rst_n    <= 1'b0;
        req      <= 1'b0;
        req_data <= '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check("reset ack", 64'd0, 64'(ack));
        check("reset rsp", 64'd0, 64'(rsp_data));

        for (int b = 0; b < `BSU_OPERAND_WIDTH; b++) begin
            run_scan(64'd1 << b, SCAN_FWD, $sformatf("single fwd bit %0d", b));
            run_scan(64'd1 << b, SCAN_REV, $sformatf("single rev bit %0d", b));
        end

        run_scan(64'd0, SCAN_FWD, "zero fwd");
        run_scan(64'd0, SCAN_REV, "zero rev");

        // both chunks get visited before the hit.
        for (int i = 0; i < CHUNK_REQ / 2; i++) begin
            operand = {$urandom(), 32'h0} | (64'd1 << (32 + $urandom_range(0, 31)));
            run_scan(operand, SCAN_FWD, $sformatf("upper chunk fwd %0d", i));
            operand = {32'h0, $urandom()} | (64'd1 << $urandom_range(0, 31));
            run_scan(operand, SCAN_REV, $sformatf("lower chunk rev %0d", i));
        end

        for (int i = 0; i < RAND_REQ; i++) begin
            operand = random_operand();
            dir     = ($urandom_range(0, 1) == 0) ? SCAN_FWD : SCAN_REV;
            run_scan(operand, dir, $sformatf("random %0d", i));
        end

        check("response count", 64'(n_sent), 64'(n_checked));
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/bit_scan_pkg.sv
logic/priority_encoder32.sv
logic/scan_datapath.sv
logic/chunk_counter.sv
logic/bit_scan_fsm.sv
logic/bit_scan_unit.sv
bench/bit_scan_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the bit-scan unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log
BIN=sim_bit_scan

verilator --binary --timing --assert -Wno-fatal \
    --top-module bit_scan_tb \
    --Mdir obj_dir \
    -o "$BIN" \
    -f project.f

# the simulator exits non-zero on a fatal check; the log decides.
./obj_dir/"$BIN" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "TEST OK" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi
